/* hdl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width.
`define XLEN 32

// Issue queue entries, power of two.
`define QUEUE_DEPTH 4

// One quotient bit per iteration.
`define DIV_STEPS `XLEN

`endif

/* hdl/common.sv */
package common;

        typedef enum logic [6:0] {
                OP      = 7'b0110011,
                OP_IMM  = 7'b0010011,
                U_LUI   = 7'b0110111,
                U_AUIPC = 7'b0010111,
                J_JAL   = 7'b1101111,
                JALR    = 7'b1100111,
                OTHER   = 7'b0000000 // Any major opcode not handled here.
        } instruction_format_type;

        typedef enum logic [3:0] {
                ADD,
                SUB,
                SLL,
                SLT,
                SLTU,
                XOR,
                SRL,
                SRA,
                OR,
                AND,
                LUI,
                AUIPC,
                DIV,
                DIVU,
                REM,
                REMU
        } alu_operation_type;

        typedef enum logic [1:0] {
                IDLE,
                RUN,
                DONE // Result register holds the divide result.
        } div_state_type;

endpackage

/* hdl/alu_ctrl.sv */
`timescale 1ns/1ns

module alu_ctrl import common::*; (
        input instruction_format_type   opcode,
        input logic [2:0]               funct3,
        input logic [6:0]               funct7,
        output alu_operation_type       op,
        output logic                    m_unsupported
);

localparam logic [6:0] F7_ALT = 7'b0100000;
localparam logic [6:0] F7_MUL = 7'b0000001;

logic m_ext;

assign m_ext = (opcode == OP) && (funct7 == F7_MUL);

// The multiply half of the M extension is not built.
assign m_unsupported = m_ext && !funct3[2];

always_comb
begin
        op = ADD; // JAL, JALR and anything dropped.

        if (opcode == OP || opcode == OP_IMM)
        begin
                case (funct3)
                        3'b000:
                                if (opcode == OP && funct7 == F7_ALT)
                                        op = SUB;
                                else
                                        op = ADD;
                        3'b001:
                                op = SLL;
                        3'b010:
                                op = SLT;
                        3'b011:
                                op = SLTU;
                        3'b100:
                                op = m_ext ? DIV : XOR;
                        3'b101:
                                if (m_ext)
                                        op = DIVU;
                                else if (funct7 == F7_ALT)
                                        op = SRA;
                                else
                                        op = SRL;
                        3'b110:
                                op = m_ext ? REM : OR;
                        3'b111:
                                op = m_ext ? REMU : AND;
                        default:
                                op = ADD;
                endcase
        end
        else if (opcode == U_LUI)
        begin
                op = LUI;
        end
        else if (opcode == U_AUIPC)
        begin
                op = AUIPC; // Same as ADD, kept explicit.
        end

        assert (!$isunknown(op))
        else
                $error("alu_ctrl: op is unknown.");
end

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module instr_decode import common::*; (
        input logic                     clk,
        input logic                     rst_n,
        input logic [31:0]              instr,
        input logic [`XLEN-1:0]         pc,
        input logic [`XLEN-1:0]         rs1_val,
        input logic [`XLEN-1:0]         rs2_val,
        input logic                     instr_valid,
        input logic                     full,
        output logic                    wr_en,
        output alu_operation_type       wr_op,
        output logic [`XLEN-1:0]        wr_a,
        output logic [`XLEN-1:0]        wr_b,
        output logic [4:0]              wr_rd,
        output logic                    illegal
);

instruction_format_type opcode;
logic [2:0]             funct3;
logic [6:0]             funct7;
logic                   m_unsupported;
logic                   legal;
logic [`XLEN-1:0]       imm_i;
logic [`XLEN-1:0]       imm_u;

assign funct3 = instr[14:12];
assign funct7 = instr[31:25];
assign wr_rd  = instr[11:7];

assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
assign imm_u = {instr[31:12], 12'b0};

always_comb
begin
        case (instr[6:0])
                OP, OP_IMM, U_LUI, U_AUIPC, J_JAL, JALR:
                        opcode = instruction_format_type'(instr[6:0]);
                default:
                        opcode = OTHER;
        endcase
end

alu_ctrl alu_ctrl_i (
        .opcode         (opcode),
        .funct3         (funct3),
        .funct7         (funct7),
        .op             (wr_op),
        .m_unsupported  (m_unsupported)
);

always_comb
begin
        wr_a = '0;
        wr_b = '0;

        case (opcode)
                OP:
                begin
                        wr_a = rs1_val;
                        wr_b = rs2_val;
                end
                OP_IMM:
                begin
                        wr_a = rs1_val;
                        wr_b = imm_i;
                end
                U_LUI:
                        wr_b = imm_u;
                U_AUIPC:
                begin
                        wr_a = pc;
                        wr_b = imm_u;
                end
                J_JAL, JALR:
                begin
                        wr_a = pc; // Link address.
                        wr_b = `XLEN'd4;
                end
                default:
                        wr_b = '0;
        endcase
end

assign legal = (opcode != OTHER) && !m_unsupported;
assign wr_en = instr_valid && legal && !full;

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
                illegal <= 1'b0;
        else
                illegal <= instr_valid && !full && !legal; // Consumed and dropped.
end

endmodule

/* hdl/issue_queue.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module issue_queue import common::*; #(
        parameter int DEPTH = `QUEUE_DEPTH
) (
        input logic                     clk,
        input logic                     rst_n,
        input logic                     wr_en,
        input alu_operation_type        wr_op,
        input logic [`XLEN-1:0]         wr_a,
        input logic [`XLEN-1:0]         wr_b,
        input logic [4:0]               wr_rd,
        input logic                     pop,
        output alu_operation_type       rd_op,
        output logic [`XLEN-1:0]        rd_a,
        output logic [`XLEN-1:0]        rd_b,
        output logic [4:0]              rd_rd,
        output logic                    full,
        output logic                    empty
);

localparam int PTR_W = $clog2(DEPTH);

alu_operation_type      op_mem [DEPTH];
logic [`XLEN-1:0]       a_mem [DEPTH];
logic [`XLEN-1:0]       b_mem [DEPTH];
logic [4:0]             rd_mem [DEPTH];

logic [PTR_W-1:0]       wr_ptr;
logic [PTR_W-1:0]       rd_ptr;
logic [PTR_W:0]         count;

assign full  = (count == (PTR_W+1)'(DEPTH));
assign empty = (count == '0);

assign rd_op = op_mem[rd_ptr];
assign rd_a  = a_mem[rd_ptr];
assign rd_b  = b_mem[rd_ptr];
assign rd_rd = rd_mem[rd_ptr];

always_ff @(posedge clk)
begin
        if (wr_en)
        begin
                op_mem[wr_ptr] <= wr_op;
                a_mem[wr_ptr]  <= wr_a;
                b_mem[wr_ptr]  <= wr_b;
                rd_mem[wr_ptr] <= wr_rd;
        end
end

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end
        else
        begin
                if (wr_en)
                        wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two.
                if (pop)
                        rd_ptr <= rd_ptr + 1'b1;
                if (wr_en && !pop)
                        count <= count + 1'b1;
                else if (pop && !wr_en)
                        count <= count - 1'b1;
        end
end

a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> !wr_en)
        else $error("issue_queue: write while full.");

a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
        else $error("issue_queue: pop while empty.");

endmodule

/* hdl/alu_unit.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module alu_unit import common::*; (
        input logic                     clk,
        input logic                     rst_n,
        input alu_operation_type        rd_op,
        input logic [`XLEN-1:0]         rd_a,
        input logic [`XLEN-1:0]         rd_b,
        input logic [4:0]               rd_rd,
        input logic                     empty,
        output logic                    pop,
        output logic                    result_valid,
        output logic [`XLEN-1:0]        result,
        output logic [4:0]              result_rd
);

localparam int SHW   = $clog2(`XLEN);
localparam int CNT_W = $clog2(`DIV_STEPS);

div_state_type          state;
logic [CNT_W-1:0]       cnt;
logic                   last_step;

logic                   is_div;
logic                   div_signed;
logic [`XLEN-1:0]       alu_res;
logic [`XLEN-1:0]       mag_a;
logic [`XLEN-1:0]       mag_b;

logic [`XLEN-1:0]       rem_q;
logic [`XLEN-1:0]       quo_q;
logic [`XLEN-1:0]       div_q;
logic                   rem_sel;
logic                   neg_q;
logic                   neg_r;

logic [`XLEN:0]         shifted;
logic [`XLEN:0]         diff;
logic [`XLEN-1:0]       rem_nxt;
logic [`XLEN-1:0]       quo_nxt;

assign pop = (state == IDLE) && !empty;

assign is_div     = rd_op inside {DIV, DIVU, REM, REMU};
assign div_signed = rd_op inside {DIV, REM};
assign last_step  = (state == RUN) && (cnt == CNT_W'(`DIV_STEPS-1));

always_comb
begin
        case (rd_op)
                ADD:    alu_res = rd_a + rd_b;
                SUB:    alu_res = rd_a - rd_b;
                SLL:    alu_res = rd_a << rd_b[SHW-1:0];
                SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(rd_a) < $signed(rd_b)};
                SLTU:   alu_res = {{(`XLEN-1){1'b0}}, rd_a < rd_b};
                XOR:    alu_res = rd_a ^ rd_b;
                SRL:    alu_res = rd_a >> rd_b[SHW-1:0];
                SRA:    alu_res = $unsigned($signed(rd_a) >>> rd_b[SHW-1:0]);
                OR:     alu_res = rd_a | rd_b;
                AND:    alu_res = rd_a & rd_b;
                LUI:    alu_res = rd_b;
                AUIPC:  alu_res = rd_a + rd_b;
                default:
                        alu_res = '0; // Divides go through the divider.
        endcase
end

// Divider runs on magnitudes.
assign mag_a = (div_signed && rd_a[`XLEN-1]) ? -rd_a : rd_a;
assign mag_b = (div_signed && rd_b[`XLEN-1]) ? -rd_b : rd_b;

// One restoring step: shift in the next dividend bit, try to subtract.
assign shifted = {rem_q, quo_q[`XLEN-1]};
assign diff    = shifted - {1'b0, div_q};
assign rem_nxt = diff[`XLEN] ? shifted[`XLEN-1:0] : diff[`XLEN-1:0];
assign quo_nxt = {quo_q[`XLEN-2:0], !diff[`XLEN]};

always_ff @(posedge clk or negedge rst_n)
begin
        if (!rst_n)
        begin
                state        <= IDLE;
                cnt          <= '0;
                result_valid <= 1'b0;
        end
        else
        begin
                result_valid <= 1'b0;
                case (state)
                        IDLE:
                        begin
                                result_valid <= pop && !is_div;
                                cnt          <= '0;
                                if (pop && is_div)
                                        state <= RUN;
                        end
                        RUN:
                        begin
                                cnt <= cnt + 1'b1;
                                if (last_step)
                                begin
                                        state        <= DONE;
                                        result_valid <= 1'b1;
                                end
                        end
                        DONE:
                                state <= IDLE; // Result shown this cycle.
                        default:
                                state <= IDLE;
                endcase
        end
end

always_ff @(posedge clk)
begin
        if (pop)
        begin
                result_rd <= rd_rd;
                if (!is_div)
                begin
                        result <= alu_res;
                end
                else
                begin
                        rem_q   <= '0;
                        quo_q   <= mag_a;
                        div_q   <= mag_b;
                        rem_sel <= rd_op inside {REM, REMU};
                        // Zero divisor keeps the all-ones quotient unsigned.
                        neg_q   <= div_signed && (rd_a[`XLEN-1] ^ rd_b[`XLEN-1])
                                   && (rd_b != '0);
                        neg_r   <= div_signed && rd_a[`XLEN-1];
                end
        end
        else if (state == RUN)
        begin
                rem_q <= rem_nxt;
                quo_q <= quo_nxt;
                if (last_step)
                begin
                        if (rem_sel)
                                result <= neg_r ? -rem_nxt : rem_nxt;
                        else
                                result <= neg_q ? -quo_nxt : quo_nxt;
                end
        end
end

a_pop_idle: assert property (@(posedge clk) disable iff (!rst_n) pop |-> state == IDLE)
        else $error("alu_unit: pop outside IDLE.");

a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        state == DONE |-> result_valid ##1 !result_valid)
        else $error("alu_unit: divide result_valid not a single-cycle pulse.");

a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        pop && is_div |-> ##(`DIV_STEPS+1) result_valid)
        else $error("alu_unit: divide result late.");

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module exec_top import common::*; (
        input logic                     clk,
        input logic                     rst_n,
        input logic [31:0]              instr,
        input logic [`XLEN-1:0]         pc,
        input logic [`XLEN-1:0]         rs1_val,
        input logic [`XLEN-1:0]         rs2_val,
        input logic                     instr_valid,
        output logic                    full,
        output logic                    illegal,
        output logic                    result_valid,
        output logic [`XLEN-1:0]        result,
        output logic [4:0]              result_rd
);

logic                   wr_en;
alu_operation_type      wr_op;
logic [`XLEN-1:0]       wr_a;
logic [`XLEN-1:0]       wr_b;
logic [4:0]             wr_rd;

alu_operation_type      rd_op;
logic [`XLEN-1:0]       rd_a;
logic [`XLEN-1:0]       rd_b;
logic [4:0]             rd_rd;
logic                   empty;
logic                   pop;

instr_decode instr_decode_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .pc             (pc),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .instr_valid    (instr_valid),
        .full           (full),
        .wr_en          (wr_en),
        .wr_op          (wr_op),
        .wr_a           (wr_a),
        .wr_b           (wr_b),
        .wr_rd          (wr_rd),
        .illegal        (illegal)
);

issue_queue #(
        .DEPTH          (`QUEUE_DEPTH)
) issue_queue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_op          (wr_op),
        .wr_a           (wr_a),
        .wr_b           (wr_b),
        .wr_rd          (wr_rd),
        .pop            (pop),
        .rd_op          (rd_op),
        .rd_a           (rd_a),
        .rd_b           (rd_b),
        .rd_rd          (rd_rd),
        .full           (full),
        .empty          (empty)
);

alu_unit alu_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_op          (rd_op),
        .rd_a           (rd_a),
        .rd_b           (rd_b),
        .rd_rd          (rd_rd),
        .empty          (empty),
        .pop            (pop),
        .result_valid   (result_valid),
        .result         (result),
        .result_rd      (result_rd)
);

endmodule

/* bench/exec_tb.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module exec_tb;

localparam int NUM_INSTR    = 300;
localparam int RANDOM_COUNT = 275;
localparam int CYCLE_LIMIT  = NUM_INSTR * (`DIV_STEPS + 2) + 200;

localparam logic [6:0] OPC_OP    = 7'b0110011;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_JAL   = 7'b1101111;
localparam logic [6:0] OPC_JALR  = 7'b1100111;

logic                   clk;
logic                   rst_n;
logic [31:0]            instr;
logic [`XLEN-1:0]       pc;
logic [`XLEN-1:0]       rs1_val;
logic [`XLEN-1:0]       rs2_val;
logic                   instr_valid;
logic                   full;
logic                   illegal;
logic                   result_valid;
logic [`XLEN-1:0]       result;
logic [4:0]             result_rd;

logic [31:0]            lcg_state = 32'hd706c12b;
logic [36:0]            exp_q [$]; // {rd, value} in program order.
logic [36:0]            head;
logic                   illegal_exp = 1'b0;
logic                   full_seen = 1'b0;
int                     errors = 0;
int                     results = 0;
int                     illegal_seen = 0;
int                     sent = 0;
int                     cycles = 0;

exec_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .pc             (pc),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .instr_valid    (instr_valid),
        .full           (full),
        .illegal        (illegal),
        .result_valid   (result_valid),
        .result         (result),
        .result_rd      (result_rd)
);

always #50 clk = ~clk;

function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

function automatic int pick(input int n);
        logic [31:0] r;
        r = lcg_next() >> 16; // Upper bits have the longer period.
        return int'(r % 32'(n));
endfunction

function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, rd, opc};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
                3'b000:  if (alt) return a - b; else return a + b;
                3'b001:  return a << b[4:0];
                3'b010:  return {31'b0, $signed(a) < $signed(b)};
                3'b011:  return {31'b0, a < b};
                3'b100:  return a ^ b;
                3'b101:  if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
                3'b110:  return a | b;
                default: return a & b;
        endcase
endfunction

function automatic logic [31:0] div_ref(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
        logic overflow;
        overflow = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
        if (y == '0)
                return f3[1] ? x : 32'hffff_ffff; // Remainder keeps the dividend.
        case (f3)
                3'b100:  if (overflow) return x; else return $signed(x) / $signed(y);
                3'b101:  return x / y;
                3'b110:  if (overflow) return '0; else return $signed(x) % $signed(y);
                default: return x % y;
        endcase
endfunction

function automatic void model(input logic [31:0] ins, input logic [31:0] pc_v,
                              input logic [31:0] a, input logic [31:0] b,
                              output bit ok, output logic [31:0] val);
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [31:0]    imm_i;
        logic [31:0]    imm_u;
        f3 = ins[14:12];
        f7 = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'b0};
        ok = 1'b1;
        val = '0;
        case (ins[6:0])
                OPC_OP:
                        if (f7 == 7'h01)
                        begin
                                ok = f3[2]; // Multiplies are dropped.
                                val = div_ref(f3, a, b);
                        end
                        else
                                val = alu_ref(f3, f7 == 7'h20, a, b);
                OPC_IMM:
                        val = alu_ref(f3, (f7 == 7'h20) && (f3 == 3'b101), a, imm_i);
                OPC_LUI:
                        val = imm_u;
                OPC_AUIPC:
                        val = pc_v + imm_u;
                OPC_JAL, OPC_JALR:
                        val = pc_v + 32'd4;
                default:
                        ok = 1'b0;
        endcase
endfunction

task automatic send(input logic [31:0] ins, input logic [31:0] pc_v,
                    input logic [31:0] a, input logic [31:0] b);
        bit             ok;
        logic [31:0]    val;
        instr <= ins;
        pc <= pc_v;
        rs1_val <= a;
        rs2_val <= b;
        instr_valid <= 1'b1;
        @(posedge clk);
        while (full)
                @(posedge clk); // Hold while the queue is full.
        model(ins, pc_v, a, b, ok, val);
        if (ok)
                exp_q.push_back({ins[11:7], val});
        else
                illegal_exp = 1'b1;
        sent++;
endtask

task automatic idle(input int n);
        instr_valid <= 1'b0;
        repeat (n) @(posedge clk);
endtask

task automatic send_random();
        logic [31:0]    ins;
        logic [31:0]    tmp;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [6:0]     f7;
        logic [2:0]     f3;
        logic [4:0]     rd;
        int             cls;
        cls = pick(10);
        f3 = 3'(pick(8));
        rd = 5'(pick(32));
        tmp = lcg_next();
        a = lcg_next();
        b = lcg_next();
        case (cls)
                0, 1, 2:
                begin
                        f7 = (pick(3) == 0) ? 7'h01 : ((pick(2) == 0) ? 7'h20 : 7'h00);
                        ins = encode_r(f7, f3, rd, OPC_OP);
                end
                3, 4:
                begin
                        f7 = (pick(2) == 0) ? tmp[31:25] : {1'b0, tmp[31], 5'b0};
                        ins = {f7, tmp[24:15], f3, rd, OPC_IMM};
                end
                5:
                        ins = {tmp[31:12], rd, OPC_LUI};
                6:
                        ins = {tmp[31:12], rd, OPC_AUIPC};
                7:
                        ins = {tmp[31:12], rd, tmp[20] ? OPC_JAL : OPC_JALR};
                8:
                        ins = tmp; // Mostly unknown major opcodes.
                default:
                begin
                        ins = encode_r(7'h01, {1'b1, f3[1:0]}, rd, OPC_OP);
                        if (tmp[5])
                                b = {29'b0, tmp[8:6]};
                end
        endcase
        send(ins, tmp & 32'hffff_fffc, a, b);
endtask

always @(posedge clk)
begin
        cycles++;
        if (cycles == CYCLE_LIMIT)
        begin
                $display("Test timed out after %0d cycles with results still pending.", cycles);
                $display("*** TEST FAILED ***");
                $finish;
        end
end

always @(negedge clk)
begin
        if (rst_n)
        begin
                if (full)
                        full_seen = 1'b1;
                assert (illegal == illegal_exp)
                else
                begin
                        $display("[ERROR] %0t: illegal is %b, expected %b", $time, illegal,
                                 illegal_exp);
                        errors++;
                end
                if (illegal)
                        illegal_seen++;
                illegal_exp = 1'b0;
                if (result_valid)
                begin
                        assert (exp_q.size() != 0)
                        else
                        begin
                                $display("[ERROR] %0t: result with nothing outstanding", $time);
                                errors++;
                        end
                        if (exp_q.size() != 0)
                        begin
                                head = exp_q.pop_front();
                                results++;
                                assert ({result_rd, result} == head)
                                else
                                begin
                                        $display("[ERROR] %0t: got x%0d=%h, expected x%0d=%h",
                                                 $time, result_rd, result, head[36:32],
                                                 head[31:0]);
                                        errors++;
                                end
                        end
                end
        end
end

initial
begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr = '0;
        pc = '0;
        rs1_val = '0;
        rs2_val = '0;
        instr_valid = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!result_valid && !illegal && !full)
        else
        begin
                $display("[ERROR] %0t: outputs not idle after reset", $time);
                errors++;
        end
        @(posedge clk);
        for (int f = 4; f < 8; f++) // Divide corner cases.
        begin
                send(encode_r(7'h01, 3'(f), 5'(f), OPC_OP), 32'h100, 32'h1234_5678, 32'h0);
                send(encode_r(7'h01, 3'(f), 5'(f), OPC_OP), 32'h104, 32'h8000_0000,
                     32'hffff_ffff);
                send(encode_r(7'h01, 3'(f), 5'(f), OPC_OP), 32'h108, 32'hffff_fff9, 32'h2);
        end
        for (int f = 0; f < 4; f++)
                send(encode_r(7'h01, 3'(f), 5'd3, OPC_OP), 32'h200, 32'd5, 32'd6);
        send(encode_r(7'h00, 3'b010, 5'd4, 7'b0000011), 32'h210, '0, '0); // A load.
        for (int i = 0; i < 8; i++) // Back-to-back divides fill the queue.
                send(encode_r(7'h01, 3'(4 + pick(4)), 5'(i + 8), OPC_OP), 32'h300,
                     lcg_next(), lcg_next());
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
                idle(pick(3));
                send_random();
        end
        idle(0);
        while (exp_q.size() != 0)
                @(posedge clk);
        repeat (3) @(posedge clk);
        assert (full_seen)
        else
        begin
                $display("The issue queue never reported full during the divide burst.");
                errors++;
        end
        assert (results + illegal_seen == sent)
        else
        begin
                $display("Instructions were lost: %0d sent, %0d results, %0d illegal pulses.",
                         sent, results, illegal_seen);
                errors++;
        end
        $display("Summary: %0d errors, %0d results, %0d illegal pulses, %0d instructions",
                 errors, results, illegal_seen, sent);
        if (errors == 0)
                $display("*** TEST PASSED ***");
        else
                $display("*** TEST FAILED ***");
        $finish;
end

endmodule

/* exec_top.f */
+incdir+hdl
hdl/common.sv
hdl/alu_ctrl.sv
hdl/instr_decode.sv
hdl/issue_queue.sv
hdl/alu_unit.sv
hdl/exec_top.sv
bench/exec_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_tb
FILELIST  = exec_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
